// ==== include/synth_settings.svh ====
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// note number and period widths
`define SYNTH_NOTE_W     7
`define SYNTH_PERIOD_W   16

// voice count, fixed by the two-way arbiter
`define SYNTH_NUM_VOICES 2

// ROM output after reset, the A4 period
`define SYNTH_ROM_RESET  1804

`endif

// ==== verilog/synth_pkg.sv ====
`include "synth_settings.svh"

package synth_pkg;

   typedef logic [`SYNTH_NOTE_W-1:0]   note_t;
   // period in clock cycles, 0 is silent
   typedef logic [`SYNTH_PERIOD_W-1:0] period_t;
   typedef logic [`SYNTH_PERIOD_W-1:0] sample_t;
   typedef logic [`SYNTH_PERIOD_W:0]   mix_t;

   // note_off has priority over note_on
   typedef struct packed {
      logic  note_on;
      logic  note_off;
      note_t note;
   } voice_cmd_t;

   typedef enum logic [1:0] {
      VOICE_IDLE,
      VOICE_FETCH,
      VOICE_WAIT,
      VOICE_RUN
   } voice_state_e;

   typedef struct packed {
      logic  req;
      note_t note;
   } rom_req_t;

endpackage

// ==== verilog/note_period_rom.sv ====
`include "synth_settings.svh"

module note_period_rom import synth_pkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    en,
   input  note_t   addr,
   output period_t data_out
);

   period_t table_val;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // note to period table, notes outside 12..119 are silent
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      case (addr)
         7'd12:   table_val = 16'd48537;
         7'd13:   table_val = 16'd45812;
         7'd14:   table_val = 16'd43241;
         7'd15:   table_val = 16'd40814;
         7'd16:   table_val = 16'd38524;
         7'd17:   table_val = 16'd36361;
         7'd18:   table_val = 16'd34321;
         7'd19:   table_val = 16'd32394;
         7'd20:   table_val = 16'd30576;
         7'd21:   table_val = 16'd28860;
         7'd22:   table_val = 16'd27240;
         7'd23:   table_val = 16'd25711;
         7'd24:   table_val = 16'd24268;
         7'd25:   table_val = 16'd22906;
         7'd26:   table_val = 16'd21621;
         7'd27:   table_val = 16'd20407;
         7'd28:   table_val = 16'd19262;
         7'd29:   table_val = 16'd18181;
         7'd30:   table_val = 16'd17160;
         7'd31:   table_val = 16'd16197;
         7'd32:   table_val = 16'd15288;
         7'd33:   table_val = 16'd14430;
         7'd34:   table_val = 16'd13620;
         7'd35:   table_val = 16'd12856;
         7'd36:   table_val = 16'd12134;
         7'd37:   table_val = 16'd11453;
         7'd38:   table_val = 16'd10810;
         7'd39:   table_val = 16'd10204;
         7'd40:   table_val = 16'd9631;
         7'd41:   table_val = 16'd9090;
         7'd42:   table_val = 16'd8580;
         7'd43:   table_val = 16'd8099;
         7'd44:   table_val = 16'd7644;
         7'd45:   table_val = 16'd7215;
         7'd46:   table_val = 16'd6810;
         7'd47:   table_val = 16'd6428;
         7'd48:   table_val = 16'd6067;
         7'd49:   table_val = 16'd5727;
         7'd50:   table_val = 16'd5405;
         7'd51:   table_val = 16'd5102;
         7'd52:   table_val = 16'd4815;
         7'd53:   table_val = 16'd4545;
         7'd54:   table_val = 16'd4290;
         7'd55:   table_val = 16'd4049;
         7'd56:   table_val = 16'd3822;
         7'd57:   table_val = 16'd3608;
         7'd58:   table_val = 16'd3405;
         7'd59:   table_val = 16'd3214;
         7'd60:   table_val = 16'd3034;
         7'd61:   table_val = 16'd2863;
         7'd62:   table_val = 16'd2703;
         7'd63:   table_val = 16'd2551;
         7'd64:   table_val = 16'd2408;
         7'd65:   table_val = 16'd2273;
         7'd66:   table_val = 16'd2145;
         7'd67:   table_val = 16'd2025;
         7'd68:   table_val = 16'd1911;
         // A4
         7'd69:   table_val = 16'd1804;
         7'd70:   table_val = 16'd1703;
         7'd71:   table_val = 16'd1607;
         7'd72:   table_val = 16'd1517;
         7'd73:   table_val = 16'd1432;
         7'd74:   table_val = 16'd1351;
         7'd75:   table_val = 16'd1275;
         7'd76:   table_val = 16'd1204;
         7'd77:   table_val = 16'd1136;
         7'd78:   table_val = 16'd1073;
         7'd79:   table_val = 16'd1012;
         7'd80:   table_val = 16'd956;
         7'd81:   table_val = 16'd902;
         7'd82:   table_val = 16'd851;
         7'd83:   table_val = 16'd803;
         7'd84:   table_val = 16'd758;
         7'd85:   table_val = 16'd716;
         7'd86:   table_val = 16'd676;
         7'd87:   table_val = 16'd638;
         7'd88:   table_val = 16'd602;
         7'd89:   table_val = 16'd568;
         7'd90:   table_val = 16'd536;
         7'd91:   table_val = 16'd506;
         7'd92:   table_val = 16'd478;
         7'd93:   table_val = 16'd451;
         7'd94:   table_val = 16'd426;
         7'd95:   table_val = 16'd402;
         7'd96:   table_val = 16'd379;
         7'd97:   table_val = 16'd358;
         7'd98:   table_val = 16'd338;
         7'd99:   table_val = 16'd319;
         7'd100:  table_val = 16'd301;
         7'd101:  table_val = 16'd284;
         7'd102:  table_val = 16'd268;
         7'd103:  table_val = 16'd253;
         7'd104:  table_val = 16'd239;
         7'd105:  table_val = 16'd225;
         7'd106:  table_val = 16'd213;
         7'd107:  table_val = 16'd201;
         7'd108:  table_val = 16'd190;
         7'd109:  table_val = 16'd179;
         7'd110:  table_val = 16'd169;
         7'd111:  table_val = 16'd159;
         7'd112:  table_val = 16'd150;
         7'd113:  table_val = 16'd142;
         7'd114:  table_val = 16'd134;
         7'd115:  table_val = 16'd127;
         7'd116:  table_val = 16'd119;
         7'd117:  table_val = 16'd113;
         7'd118:  table_val = 16'd106;
         7'd119:  table_val = 16'd100;
         default: table_val = 16'd0;
      endcase
   end

   // registered read, output holds between enables
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         data_out <= period_t'(`SYNTH_ROM_RESET);
      end
      else if (en)
      begin
         data_out <= table_val;
      end
   end

endmodule

// ==== verilog/rom_arbiter.sv ====
`include "synth_settings.svh"

module rom_arbiter import synth_pkg::*; (
   input  logic                         clk,
   input  logic                         rstn,
   input  rom_req_t                     voice_req [`SYNTH_NUM_VOICES],
   output logic [`SYNTH_NUM_VOICES-1:0] grant,
   output logic [`SYNTH_NUM_VOICES-1:0] rsp_valid,
   output logic                         rom_en,
   output note_t                        rom_addr
);

   // index of the voice served last
   logic last;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // round-robin grant
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      grant = '0;
      if (voice_req[0].req && voice_req[1].req)
      begin
         // collision, the voice not served last wins
         grant = last ? 2'b01 : 2'b10;
      end
      else if (voice_req[0].req)
      begin
         grant = 2'b01;
      end
      else if (voice_req[1].req)
      begin
         grant = 2'b10;
      end
   end

   assign rom_en   = |grant;
   assign rom_addr = grant[1] ? voice_req[1].note : voice_req[0].note;

   // response follows the registered ROM read by one cycle
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         last      <= 1'b1;
         rsp_valid <= '0;
      end
      else
      begin
         rsp_valid <= grant;
         if (rom_en)
            last <= grant[1];
      end
   end

endmodule

// ==== verilog/saw_voice.sv ====
module saw_voice import synth_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  voice_cmd_t cmd,
   output rom_req_t   rom_req,
   input  logic       grant,
   input  logic       rsp_valid,
   input  period_t    rom_data,
   output sample_t    sample,
   output logic       busy
);

   voice_state_e state;
   voice_state_e state_nxt;
   note_t        note_q;
   period_t      period_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // command and fetch FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      state_nxt = state;
      if (cmd.note_off)
         state_nxt = VOICE_IDLE;
      else if (cmd.note_on)
         state_nxt = VOICE_FETCH;
      else
      begin
         case (state)
            VOICE_FETCH: if (grant) state_nxt = VOICE_WAIT;
            VOICE_WAIT:
               if (rsp_valid)
                  state_nxt = (rom_data == '0) ? VOICE_IDLE : VOICE_RUN;
            default:     state_nxt = state;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state  <= VOICE_IDLE;
         sample <= '0;
      end
      else
      begin
         state <= state_nxt;
         // phase counter only advances while running, wraps at period-1
         if (state == VOICE_RUN && state_nxt == VOICE_RUN)
            sample <= (sample == period_q - 1'b1) ? '0 : sample + 1'b1;
         else
            sample <= '0;
      end
   end

   // latched note and fetched period
   always_ff @(posedge clk)
   begin
      if (cmd.note_on && !cmd.note_off)
         note_q <= cmd.note;
      if (state == VOICE_WAIT && rsp_valid)
         period_q <= rom_data;
   end

   assign rom_req.req  = (state == VOICE_FETCH);
   assign rom_req.note = note_q;
   assign busy         = (state == VOICE_FETCH) || (state == VOICE_WAIT);

endmodule

// ==== verilog/saw_synth_top.sv ====
`include "synth_settings.svh"

module saw_synth_top import synth_pkg::*; (
   input  logic                         clk,
   input  logic                         rstn,
   input  voice_cmd_t                   cmd    [`SYNTH_NUM_VOICES],
   output sample_t                      sample [`SYNTH_NUM_VOICES],
   output logic [`SYNTH_NUM_VOICES-1:0] busy,
   output mix_t                         mix
);

   // shared ROM bus
   rom_req_t                     voice_req [`SYNTH_NUM_VOICES];
   logic [`SYNTH_NUM_VOICES-1:0] grant;
   logic [`SYNTH_NUM_VOICES-1:0] rsp_valid;
   logic                         rom_en;
   note_t                        rom_addr;
   period_t                      rom_data;

   note_period_rom u_rom (
      .clk      (clk),
      .rstn     (rstn),
      .en       (rom_en),
      .addr     (rom_addr),
      .data_out (rom_data)
   );

   rom_arbiter u_arb (
      .clk       (clk),
      .rstn      (rstn),
      .voice_req (voice_req),
      .grant     (grant),
      .rsp_valid (rsp_valid),
      .rom_en    (rom_en),
      .rom_addr  (rom_addr)
   );

   saw_voice u_voice0 (
      .clk       (clk),
      .rstn      (rstn),
      .cmd       (cmd[0]),
      .rom_req   (voice_req[0]),
      .grant     (grant[0]),
      .rsp_valid (rsp_valid[0]),
      .rom_data  (rom_data),
      .sample    (sample[0]),
      .busy      (busy[0])
   );

   saw_voice u_voice1 (
      .clk       (clk),
      .rstn      (rstn),
      .cmd       (cmd[1]),
      .rom_req   (voice_req[1]),
      .grant     (grant[1]),
      .rsp_valid (rsp_valid[1]),
      .rom_data  (rom_data),
      .sample    (sample[1]),
      .busy      (busy[1])
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // mix, one cycle behind the samples
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         mix <= '0;
      else
         mix <= mix_t'(sample[0]) + mix_t'(sample[1]);
   end

endmodule

// ==== tb/saw_synth_properties.sv ====
`include "synth_settings.svh"

module saw_synth_properties import synth_pkg::*; (
   input logic                         clk,
   input logic                         rstn,
   input logic [`SYNTH_NUM_VOICES-1:0] grant,
   input logic                         rom_en,
   input sample_t                      sample0,
   input sample_t                      sample1,
   input voice_state_e                 state0,
   input voice_state_e                 state1,
   input period_t                      period0,
   input period_t                      period1
);

   timeunit 1ns;
   timeprecision 100ps;

   grant_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(grant))
      else $error("arbiter granted more than one voice in a cycle");

   // ROM read only for a granted voice that is fetching
   en_needs_grant: assert property (@(posedge clk) disable iff (!rstn)
      rom_en |-> ((grant[0] && state0 == VOICE_FETCH) ||
                  (grant[1] && state1 == VOICE_FETCH)))
      else $error("ROM read enabled without a grant to a fetching voice");

   // ramp never reaches the period while running
   run0_below_period: assert property (@(posedge clk) disable iff (!rstn)
      (state0 == VOICE_RUN) |-> (sample0 < period0))
      else $error("voice 0 sample reached its period");

   run1_below_period: assert property (@(posedge clk) disable iff (!rstn)
      (state1 == VOICE_RUN) |-> (sample1 < period1))
      else $error("voice 1 sample reached its period");

endmodule

// ==== tb/saw_synth_tb.sv ====
`include "synth_settings.svh"

module saw_synth_tb import synth_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int M_IDLE = 0;
   localparam int M_BUSY = 1;
   localparam int M_RUN  = 2;
   // busy lasts two cycles, three when both voices ask at once
   localparam int MIN_FETCH = 2;
   localparam int MAX_FETCH = 3;
   // tests need about 12k cycles at worst, two A4 periods in the sharing runs
   localparam int TIMEOUT_CYCLES = 20000;

   logic                         clk = 1'b0;
   logic                         rstn;
   voice_cmd_t                   cmd    [`SYNTH_NUM_VOICES];
   sample_t                      sample [`SYNTH_NUM_VOICES];
   logic [`SYNTH_NUM_VOICES-1:0] busy;
   mix_t                         mix;

   // expected voice model
   int      exp_mode    [`SYNTH_NUM_VOICES] = '{M_IDLE, M_IDLE};
   int      fetch_cnt   [`SYNTH_NUM_VOICES] = '{0, 0};
   note_t   exp_note    [`SYNTH_NUM_VOICES] = '{7'd0, 7'd0};
   period_t exp_period  [`SYNTH_NUM_VOICES] = '{16'd0, 16'd0};
   sample_t exp_phase   [`SYNTH_NUM_VOICES] = '{16'd0, 16'd0};
   sample_t prev_sample [`SYNTH_NUM_VOICES] = '{16'd0, 16'd0};
   int      cycle_count = 0;
   integer  seed = 32'h9a7b;
   note_t   tone_notes [4] = '{7'd69, 7'd100, 7'd110, 7'd119};

   saw_synth_top u_dut (
      .clk    (clk),
      .rstn   (rstn),
      .cmd    (cmd),
      .sample (sample),
      .busy   (busy),
      .mix    (mix)
   );

   bind saw_synth_top saw_synth_properties u_props (
      .clk     (clk),
      .rstn    (rstn),
      .grant   (grant),
      .rom_en  (rom_en),
      .sample0 (sample[0]),
      .sample1 (sample[1]),
      .state0  (u_voice0.state),
      .state1  (u_voice1.state),
      .period0 (u_voice0.period_q),
      .period1 (u_voice1.period_q)
   );

   always #2 clk = ~clk;

   // table values for the notes under test, outside 12..119 is silent
   function automatic period_t ref_period(input note_t note);
      period_t p;
      case (note)
         7'd69:   p = 16'd1804;
         7'd100:  p = 16'd301;
         7'd110:  p = 16'd169;
         7'd119:  p = 16'd100;
         default: p = 16'd0;
      endcase
      return p;
   endfunction

   function automatic voice_cmd_t note_on_cmd(input note_t note);
      voice_cmd_t c;
      c.note_on  = 1'b1;
      c.note_off = 1'b0;
      c.note     = note;
      return c;
   endfunction

   function automatic voice_cmd_t note_off_cmd();
      voice_cmd_t c;
      c.note_on  = 1'b0;
      c.note_off = 1'b1;
      c.note     = 7'd0;
      return c;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic run_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   // one-cycle strobe on both command ports
   task automatic drive_cmd(input voice_cmd_t c0, input voice_cmd_t c1);
      cmd[0] = c0;
      cmd[1] = c1;
      next_cycle();
      cmd[0] = '0;
      cmd[1] = '0;
   endtask

   task automatic wait_fetch();
      while (busy != '0)
         next_cycle();
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // comparison, sampled mid-cycle
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(negedge clk)
   begin
      int      v;
      sample_t exp_sample;
      logic    exp_busy;
      if (rstn)
      begin
         assert (mix === mix_t'(prev_sample[0]) + mix_t'(prev_sample[1]))
         else
         begin
            $display("Mismatch mix: got 0x%h expected 0x%h", mix,
                     mix_t'(prev_sample[0]) + mix_t'(prev_sample[1]));
            $display("*** TEST FAILED ***");
            $fatal(1, "mix check");
         end
         for (v = 0; v < `SYNTH_NUM_VOICES; v++)
         begin
            exp_busy = 1'b0;
            if (exp_mode[v] == M_BUSY)
            begin
               if (fetch_cnt[v] < MIN_FETCH || busy[v])
               begin
                  exp_busy = 1'b1;
                  fetch_cnt[v]++;
               end
               else
               begin
                  // fetch done, first ramp sample is 0
                  exp_period[v] = ref_period(exp_note[v]);
                  exp_phase[v]  = '0;
                  exp_mode[v]   = (exp_period[v] == 16'd0) ? M_IDLE : M_RUN;
               end
            end
            assert (fetch_cnt[v] <= MAX_FETCH)
            else
            begin
               $display("voice %0d still busy after %0d cycles, ROM fetch never finished",
                        v, fetch_cnt[v]);
               $display("*** TEST FAILED ***");
               $fatal(1, "fetch latency");
            end
            exp_sample = (exp_mode[v] == M_RUN) ? exp_phase[v] : 16'd0;
            assert (sample[v] === exp_sample)
            else
            begin
               $display("Mismatch sample[%0d]: got 0x%h expected 0x%h",
                        v, sample[v], exp_sample);
               $display("*** TEST FAILED ***");
               $fatal(1, "sample check");
            end
            assert (busy[v] === exp_busy)
            else
            begin
               $display("Mismatch busy[%0d]: got 0x%h expected 0x%h", v, busy[v], exp_busy);
               $display("*** TEST FAILED ***");
               $fatal(1, "busy check");
            end
            if (exp_mode[v] == M_RUN)
               exp_phase[v] = (exp_phase[v] == exp_period[v] - 16'd1) ? 16'd0
                                                                      : exp_phase[v] + 16'd1;
            // command takes effect on the next edge, note_off first
            if (cmd[v].note_off)
               exp_mode[v] = M_IDLE;
            else if (cmd[v].note_on)
            begin
               exp_mode[v]  = M_BUSY;
               exp_note[v]  = cmd[v].note;
               fetch_cnt[v] = 0;
            end
            prev_sample[v] = exp_sample;
         end
      end
      else
      begin
         exp_mode    = '{M_IDLE, M_IDLE};
         fetch_cnt   = '{0, 0};
         prev_sample = '{16'd0, 16'd0};
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("*** TEST FAILED ***");
         $fatal(1, "timeout");
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial
   begin
      int         i;
      int         idx0;
      int         idx1;
      int         longest;
      voice_cmd_t both_cmd;
      cmd[0] = '0;
      cmd[1] = '0;
      rstn   = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rstn = 1'b1;
      // idle after reset
      run_cycles(8);

      // single voice, two full periods per note
      for (i = 0; i < 4; i++)
      begin
         drive_cmd(note_on_cmd(tone_notes[i]), '0);
         wait_fetch();
         run_cycles(2 * int'(ref_period(tone_notes[i])) + 4);
         drive_cmd(note_off_cmd(), '0);
         run_cycles(4);
      end

      // both voices at once, distinct random notes
      for (i = 0; i < 2; i++)
      begin
         idx0 = int'($unsigned($random(seed)) % 32'd4);
         idx1 = (idx0 + 1 + int'($unsigned($random(seed)) % 32'd3)) % 4;
         longest = int'(ref_period(tone_notes[idx0]));
         if (int'(ref_period(tone_notes[idx1])) > longest)
            longest = int'(ref_period(tone_notes[idx1]));
         drive_cmd(note_on_cmd(tone_notes[idx0]), note_on_cmd(tone_notes[idx1]));
         wait_fetch();
         run_cycles(2 * longest + 4);
         drive_cmd(note_off_cmd(), note_off_cmd());
         run_cycles(4);
      end

      // silent notes and note_off
      drive_cmd(note_on_cmd(7'd5), note_on_cmd(7'd125));
      wait_fetch();
      run_cycles(8);
      drive_cmd(note_on_cmd(7'd100), '0);
      wait_fetch();
      run_cycles(40);
      drive_cmd(note_off_cmd(), '0);
      run_cycles(8);
      both_cmd = note_on_cmd(7'd110);
      both_cmd.note_off = 1'b1;
      drive_cmd(both_cmd, '0);
      run_cycles(8);

      // retrigger mid-ramp with a new note
      drive_cmd('0, note_on_cmd(7'd110));
      wait_fetch();
      run_cycles(100);
      drive_cmd('0, note_on_cmd(7'd119));
      wait_fetch();
      run_cycles(2 * 100 + 4);
      drive_cmd('0, note_off_cmd());
      run_cycles(4);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+include
verilog/synth_pkg.sv
verilog/note_period_rom.sv
verilog/rom_arbiter.sv
verilog/saw_voice.sv
verilog/saw_synth_top.sv
tb/saw_synth_properties.sv
tb/saw_synth_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the testbench with Verilator and run it
# the exit status of the simulation is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
   -f files.f \
   --top-module saw_synth_tb \
   -o saw_synth_sim &&
./obj_dir/saw_synth_sim ||
exit 1
